/* mini_mcu.f */
+incdir+testbench
source/mcu_pkg.sv
source/core_regfile.sv
source/core_alu.sv
source/core_ctrl_fsm.sv
source/cpu_subsystem.sv
source/periph_timer.sv
source/data_bus_demux.sv
source/mini_mcu.sv
testbench/tb_mini_mcu.sv

/* Makefile */
# Verilator build and run for the mini MCU testbench

VERILATOR ?= verilator
TOP       ?= tb_mini_mcu
FILELIST  ?= mini_mcu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail on the fail message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_mini_mcu_tests.svh */
////////////////////////////////////////////////////////////
// Program builders and directed tests for the mini MCU
////////////////////////////////////////////////////////////
`ifndef TB_MINI_MCU_TESTS_SVH
`define TB_MINI_MCU_TESTS_SVH

logic [31:0] emit_addr;
logic [31:0] saved_data [$];

function automatic logic [31:0] enc(mcu_pkg::opcode_e op, int rd, int rs1, int rs2, int imm);
    return {op, 4'(rd), 4'(rs1), 4'(rs2), 16'(imm)};
endfunction

function automatic logic [31:0] sext16(int imm);
    return {{16{imm[15]}}, imm[15:0]};
endfunction

task automatic emit(logic [31:0] word);
    mem[emit_addr[11:2]] = word;
    emit_addr            = emit_addr + 4;
endtask

// Branch offset from the BEQ about to be emitted
function automatic int br_to(logic [31:0] target);
    return (int'(target) - int'(emit_addr) - 4) / 4;
endfunction

task automatic emit_tail();
    emit(enc(mcu_pkg::OP_SW, 0, 0, 0, DONE_ADDR));
    emit(enc(mcu_pkg::OP_BEQ, 0, 0, 0, -1));  // Park
endtask

task automatic start_program(logic stall);
    @(negedge clk);
    rst_n   = 1'b0;
    ext_irq = '0;
    @(negedge clk);  // Memory model is idle from here on
    stall_mode = stall;
    done       = 1'b0;
    st_addr.delete();
    st_data.delete();
    ack_ids.delete();
    for (int i = 0; i < 1024; i++) mem[i] = {4'hF, 18'h0, i[9:0]} ^ (i * 32'h0001_0003);
    emit_addr = 32'h0;
endtask

// Reset went low one cycle earlier in start_program
task automatic release_reset();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
endtask

task automatic wait_done();
    int n;
    n = 0;
    while (!done && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (!done) begin
        $display("Timeout at %0t: program never stored to the done address", $time);
        timeouts++;
    end
endtask

task automatic run_program();
    release_reset();
    wait_done();
endtask

task automatic check_eq(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_store(int idx, logic [31:0] addr, logic [31:0] data);
    check_eq($sformatf("store %0d count", idx), 32'(st_addr.size() > idx), 32'd1);
    if (st_addr.size() > idx) begin
        check_eq($sformatf("store %0d addr", idx), st_addr[idx], addr);
        check_eq($sformatf("store %0d data", idx), st_data[idx], data);
    end
endtask

task automatic test_arith();
    logic [31:0] a, b;
    a = (32'h1234 << 16) + sext16(16'h5678);
    b = (32'h0F0F << 16) + sext16(16'hFFF0);
    start_program(1'b0);
    emit(enc(mcu_pkg::OP_LUI, 1, 0, 0, 16'h1234));
    emit(enc(mcu_pkg::OP_ADDI, 1, 1, 0, 16'h5678));
    emit(enc(mcu_pkg::OP_LUI, 2, 0, 0, 16'h0F0F));
    emit(enc(mcu_pkg::OP_ADDI, 2, 2, 0, 16'hFFF0));
    emit(enc(mcu_pkg::OP_ADD, 3, 1, 2, 0));
    emit(enc(mcu_pkg::OP_SUB, 4, 1, 2, 0));
    emit(enc(mcu_pkg::OP_AND, 5, 1, 2, 0));
    emit(enc(mcu_pkg::OP_OR, 6, 1, 2, 0));
    emit(enc(mcu_pkg::OP_XOR, 7, 1, 2, 0));
    emit(enc(mcu_pkg::OP_ADD, 0, 1, 2, 0));  // r0 stays zero
    for (int r = 3; r <= 7; r++) emit(enc(mcu_pkg::OP_SW, 0, 0, r, 16'h800 + 4 * (r - 3)));
    emit(enc(mcu_pkg::OP_SW, 0, 0, 0, 16'h814));
    emit_tail();
    run_program();
    check_store(0, 32'h800, a + b);
    check_store(1, 32'h804, a - b);
    check_store(2, 32'h808, a & b);
    check_store(3, 32'h80C, a | b);
    check_store(4, 32'h810, a ^ b);
    check_store(5, 32'h814, 32'h0);
    check_store(6, DONE_ADDR, 32'h0);
endtask

// Sums four loaded words until the BEQ on r4 sees zero
task automatic sum_program(logic stall);
    int          vals [4] = '{3, 5, 7, 9};
    logic [31:0] loop_top;
    int          sum;
    sum = 0;
    start_program(stall);
    for (int k = 0; k < 4; k++) begin
        emit(enc(mcu_pkg::OP_ADDI, 1, 0, 0, vals[k]));
        emit(enc(mcu_pkg::OP_SW, 0, 0, 1, 16'h900 + 4 * k));
        sum += vals[k];
    end
    emit(enc(mcu_pkg::OP_ADDI, 3, 0, 0, 16'h900));
    emit(enc(mcu_pkg::OP_ADDI, 4, 0, 0, 4));
    loop_top = emit_addr;
    emit(enc(mcu_pkg::OP_LW, 6, 3, 0, 0));
    emit(enc(mcu_pkg::OP_ADD, 2, 2, 6, 0));
    emit(enc(mcu_pkg::OP_ADDI, 3, 3, 0, 4));
    emit(enc(mcu_pkg::OP_ADDI, 4, 4, 0, -1));
    emit(enc(mcu_pkg::OP_ADDI, 7, 7, 0, 1));
    emit(enc(mcu_pkg::OP_BEQ, 0, 4, 0, 1));  // Skip the back branch
    emit(enc(mcu_pkg::OP_BEQ, 0, 0, 0, br_to(loop_top)));
    emit(enc(mcu_pkg::OP_SW, 0, 0, 2, 16'hA00));
    emit(enc(mcu_pkg::OP_SW, 0, 0, 7, 16'hA04));
    emit_tail();
    run_program();
    for (int k = 0; k < 4; k++) check_store(k, 32'h900 + 4 * k, vals[k]);
    check_store(4, 32'hA00, sum);
    check_store(5, 32'hA04, 32'd4);
endtask

task automatic test_load_loop();
    sum_program(1'b0);
    saved_data = st_data;
endtask

task automatic test_stalls();
    sum_program(1'b1);
    check_eq("stalled store count", st_data.size(), saved_data.size());
    for (int i = 0; i < saved_data.size() && i < st_data.size(); i++) begin
        check_eq($sformatf("stalled store %0d", i), st_data[i], saved_data[i]);
    end
endtask

task automatic test_ext_irq();
    int n;
    start_program(1'b0);
    emit(enc(mcu_pkg::OP_ADDI, 1, 0, 0, 16'h11));
    emit(enc(mcu_pkg::OP_SW, 0, 0, 1, 16'hB00));
    emit(enc(mcu_pkg::OP_WFI, 0, 0, 0, 0));
    emit(enc(mcu_pkg::OP_ADDI, 1, 0, 0, 16'h22));
    emit(enc(mcu_pkg::OP_SW, 0, 0, 1, 16'hB04));
    emit_tail();
    emit_addr = 32'h100;  // Handler
    emit(enc(mcu_pkg::OP_ADDI, 8, 0, 0, 16'h77));
    emit(enc(mcu_pkg::OP_SW, 0, 0, 8, 16'hB08));
    emit(enc(mcu_pkg::OP_IRET, 0, 0, 0, 0));
    release_reset();
    n = 0;
    while (!core_sleep && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (!core_sleep) begin
        $display("Timeout at %0t: core never went to sleep", $time);
        timeouts++;
    end
    ext_irq = 8'b0010_0100;
    n       = 0;
    while (ack_ids.size() == 0 && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (ack_ids.size() == 0) begin
        $display("Timeout at %0t: no interrupt acknowledge seen", $time);
        timeouts++;
    end
    check_eq("sleep after wake", 32'(core_sleep), 32'd0);
    ext_irq = '0;
    wait_done();
    check_eq("ext ack count", ack_ids.size(), 1);
    if (ack_ids.size() > 0) check_eq("ext ack id", ack_ids[0], 2);
    check_store(0, 32'hB00, 32'h11);
    check_store(1, 32'hB08, 32'h77);
    check_store(2, 32'hB04, 32'h22);
    check_store(3, DONE_ADDR, 32'h0);
endtask

task automatic test_timer_irq();
    logic [31:0] loop_top;
    start_program(1'b0);
    emit(enc(mcu_pkg::OP_LUI, 1, 0, 0, 16'hF000));
    emit(enc(mcu_pkg::OP_ADDI, 2, 0, 0, 40));
    emit(enc(mcu_pkg::OP_SW, 0, 1, 2, mcu_pkg::TIMER_CMP_OFS));
    emit(enc(mcu_pkg::OP_ADDI, 3, 0, 0, 1));
    emit(enc(mcu_pkg::OP_SW, 0, 1, 3, mcu_pkg::TIMER_CTRL_OFS));
    loop_top = emit_addr;
    emit(enc(mcu_pkg::OP_ADDI, 4, 4, 0, 1));
    emit(enc(mcu_pkg::OP_BEQ, 0, 5, 0, br_to(loop_top)));  // Spin until r5 set
    emit_tail();
    emit_addr = 32'h100;
    emit(enc(mcu_pkg::OP_LW, 6, 1, 0, mcu_pkg::TIMER_COUNT_OFS));
    emit(enc(mcu_pkg::OP_SW, 0, 0, 6, 16'hC00));
    emit(enc(mcu_pkg::OP_ADDI, 7, 0, 0, 3));  // Keep enabled, clear irq
    emit(enc(mcu_pkg::OP_SW, 0, 1, 7, mcu_pkg::TIMER_CTRL_OFS));
    emit(enc(mcu_pkg::OP_ADDI, 5, 0, 0, 1));
    emit(enc(mcu_pkg::OP_IRET, 0, 0, 0, 0));
    run_program();
    check_eq("timer ack count", ack_ids.size(), 1);
    if (ack_ids.size() > 0) check_eq("timer ack id", ack_ids[0], 8);
    check_eq("timer store count", st_addr.size(), 2);
    if (st_addr.size() > 0) begin
        check_eq("timer store addr", st_addr[0], 32'hC00);
        check_eq("count reached compare", 32'(st_data[0] >= 40), 32'd1);
    end
endtask

`endif

/* testbench/tb_mini_mcu.sv */
////////////////////////////////////////////////////////////
// Testbench for the mini MCU with one memory model on both
// OBI ports and optional random stalls
////////////////////////////////////////////////////////////
module tb_mini_mcu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] DONE_ADDR = 32'h0000_0FFC;
    localparam int          TIMEOUT   = 5000;  // Cycles per wait

    logic                          clk;
    logic                          rst_n;
    mcu_pkg::obi_req_t             instr_req;
    mcu_pkg::obi_resp_t            instr_resp;
    mcu_pkg::obi_req_t             data_req;
    mcu_pkg::obi_resp_t            data_resp;
    logic [7:0]                    ext_irq;
    logic                          irq_ack;
    logic [mcu_pkg::IRQ_ID_W-1:0]  irq_id;
    logic                          core_sleep;

    logic [31:0]        mem [1024];
    mcu_pkg::obi_resp_t resp [2];   // 0 instruction, 1 data
    int                 phase [2];
    int                 cnt [2];
    logic [31:0]        hold [2];
    logic [31:0]        st_addr [$];
    logic [31:0]        st_data [$];
    logic [3:0]         ack_ids [$];
    logic               done;
    logic               stall_mode;
    int                 seed = 32'habb3_9125;
    int                 errors = 0;
    int                 checks = 0;
    int                 timeouts = 0;

    mini_mcu i_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_req_o    (instr_req),
        .instr_resp_i   (instr_resp),
        .ext_data_req_o (data_req),
        .ext_data_resp_i(data_resp),
        .ext_irq_i      (ext_irq),
        .irq_ack_o      (irq_ack),
        .irq_id_o       (irq_id),
        .core_sleep_o   (core_sleep)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign instr_resp = resp[0];
    assign data_resp  = resp[1];

    function automatic int stall_delay();
        if (!stall_mode) return 0;
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic grant(int p, mcu_pkg::obi_req_t r);
        check_eq($sformatf("port %0d byte enables", p), 32'(r.be), 32'h0000_000F);
        if (p == 0) begin
            check_eq("fetch write enable", 32'(r.we), 32'd0);
            check_eq("fetch write data", r.wdata, 32'd0);
        end
        resp[p].gnt = 1'b1;
        hold[p]     = mem[r.addr[11:2]];
        if (p == 1 && r.we) begin
            mem[r.addr[11:2]] = r.wdata;
            hold[p]           = '0;
            st_addr.push_back(r.addr);
            st_data.push_back(r.wdata);
            if (r.addr == DONE_ADDR) done = 1'b1;
        end
        phase[p] = 2;
    endtask

    task automatic respond(int p);
        resp[p].rvalid = 1'b1;
        resp[p].rdata  = hold[p];
        phase[p]       = 0;
    endtask

    // Both ports change only on the falling edge
    always @(negedge clk) begin
        mcu_pkg::obi_req_t r;
        for (int p = 0; p < 2; p++) begin
            r              = (p == 0) ? instr_req : data_req;
            resp[p].gnt    = 1'b0;
            resp[p].rvalid = 1'b0;
            if (!rst_n) begin
                phase[p] = 0;
            end else begin
                case (phase[p])
                    0: if (r.req) begin
                        cnt[p] = stall_delay();
                        if (cnt[p] == 0) grant(p, r);
                        else phase[p] = 1;
                    end
                    1: begin
                        cnt[p]--;
                        if (cnt[p] == 0) grant(p, r);
                    end
                    2: begin
                        cnt[p] = stall_delay();  // Gap before rvalid
                        if (cnt[p] == 0) respond(p);
                        else phase[p] = 3;
                    end
                    default: begin
                        cnt[p]--;
                        if (cnt[p] == 0) respond(p);
                    end
                endcase
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && irq_ack) ack_ids.push_back(irq_id);
    end

    `include "tb_mini_mcu_tests.svh"

    initial begin
        rst_n      = 1'b0;
        ext_irq    = '0;
        stall_mode = 1'b0;
        done       = 1'b0;
        resp[0]    = '0;
        resp[1]    = '0;
        test_arith();
        test_load_loop();
        test_stalls();
        test_ext_irq();
        test_timer_irq();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* source/mini_mcu.sv */
////////////////////////////////////////////////////////////
// Mini MCU top level with CPU subsystem, data bus demux
// and compare timer
////////////////////////////////////////////////////////////
module mini_mcu #(
    parameter logic [31:0] BOOT_ADDR  = 32'h0000_0000,
    parameter logic [31:0] IRQ_VEC    = 32'h0000_0100,
    parameter logic [31:0] TIMER_BASE = 32'hF000_0000
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    output mcu_pkg::obi_req_t               instr_req_o,
    input  mcu_pkg::obi_resp_t              instr_resp_i,
    output mcu_pkg::obi_req_t               ext_data_req_o,
    input  mcu_pkg::obi_resp_t              ext_data_resp_i,
    input  logic [7:0]                      ext_irq_i,
    output logic                            irq_ack_o,
    output logic [mcu_pkg::IRQ_ID_W-1:0]    irq_id_o,
    output logic                            core_sleep_o
);

    mcu_pkg::obi_req_t  core_data_req;
    mcu_pkg::obi_resp_t core_data_resp;
    mcu_pkg::obi_req_t  timer_req;
    mcu_pkg::obi_resp_t timer_resp;
    logic               timer_irq;

    cpu_subsystem #(
        .BOOT_ADDR(BOOT_ADDR),
        .IRQ_VEC  (IRQ_VEC)
    ) i_cpu_subsystem (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .instr_req_o (instr_req_o),
        .instr_resp_i(instr_resp_i),
        .data_req_o  (core_data_req),
        .data_resp_i (core_data_resp),
        .irq_i       ({timer_irq, ext_irq_i}),  // Timer sits on line 8
        .irq_ack_o   (irq_ack_o),
        .irq_id_o    (irq_id_o),
        .core_sleep_o(core_sleep_o)
    );

    data_bus_demux #(
        .TIMER_BASE(TIMER_BASE)
    ) i_data_bus_demux (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .core_req_i  (core_data_req),
        .core_resp_o (core_data_resp),
        .timer_req_o (timer_req),
        .timer_resp_i(timer_resp),
        .ext_req_o   (ext_data_req_o),
        .ext_resp_i  (ext_data_resp_i)
    );

    periph_timer i_periph_timer (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .req_i  (timer_req),
        .resp_o (timer_resp),
        .irq_o  (timer_irq)
    );

endmodule

/* source/data_bus_demux.sv */
////////////////////////////////////////////////////////////
// Data bus demux, timer window or external data port
////////////////////////////////////////////////////////////
module data_bus_demux #(
    parameter logic [31:0] TIMER_BASE = 32'hF000_0000
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  mcu_pkg::obi_req_t  core_req_i,
    output mcu_pkg::obi_resp_t core_resp_o,
    output mcu_pkg::obi_req_t  timer_req_o,
    input  mcu_pkg::obi_resp_t timer_resp_i,
    output mcu_pkg::obi_req_t  ext_req_o,
    input  mcu_pkg::obi_resp_t ext_resp_i
);

    logic sel_timer;
    logic timer_q;  // Target of the outstanding access

    assign sel_timer = (core_req_i.addr[31:12] == TIMER_BASE[31:12]);

    always_comb begin
        timer_req_o     = core_req_i;
        timer_req_o.req = core_req_i.req & sel_timer;
        ext_req_o       = core_req_i;
        ext_req_o.req   = core_req_i.req & ~sel_timer;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            timer_q <= 1'b0;
        end else if (core_req_i.req && core_resp_o.gnt) begin
            timer_q <= sel_timer;
        end
    end

    // Grant follows the address, response follows the stored target
    assign core_resp_o.gnt    = sel_timer ? timer_resp_i.gnt : ext_resp_i.gnt;
    assign core_resp_o.rvalid = timer_q ? timer_resp_i.rvalid : ext_resp_i.rvalid;
    assign core_resp_o.rdata  = timer_q ? timer_resp_i.rdata : ext_resp_i.rdata;

endmodule

/* source/periph_timer.sv */
////////////////////////////////////////////////////////////
// Compare timer on OBI, free-running count with a sticky
// match interrupt
////////////////////////////////////////////////////////////
module periph_timer (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  mcu_pkg::obi_req_t  req_i,
    output mcu_pkg::obi_resp_t resp_o,
    output logic               irq_o
);

    logic [31:0] count_q, cmp_q, rdata_d, rdata_q;
    logic        en_q, pending_q, rvalid_q;
    logic        wr_count, wr_cmp, wr_ctrl;

    assign wr_count = req_i.req & req_i.we & (req_i.addr[11:0] == mcu_pkg::TIMER_COUNT_OFS);
    assign wr_cmp   = req_i.req & req_i.we & (req_i.addr[11:0] == mcu_pkg::TIMER_CMP_OFS);
    assign wr_ctrl  = req_i.req & req_i.we & (req_i.addr[11:0] == mcu_pkg::TIMER_CTRL_OFS);

    always_comb begin
        case (req_i.addr[11:0])
            mcu_pkg::TIMER_COUNT_OFS: rdata_d = count_q;
            mcu_pkg::TIMER_CMP_OFS:   rdata_d = cmp_q;
            mcu_pkg::TIMER_CTRL_OFS:  rdata_d = {30'd0, pending_q, en_q};
            default:                  rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q   <= '0;
            cmp_q     <= '0;
            en_q      <= 1'b0;
            pending_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            rvalid_q <= req_i.req;  // Response one cycle after grant
            if (wr_count) begin
                count_q <= req_i.wdata;
            end else if (en_q) begin
                count_q <= count_q + 32'd1;
            end
            if (wr_cmp) cmp_q <= req_i.wdata;
            if (wr_ctrl) en_q <= req_i.wdata[0];
            if (en_q && count_q == cmp_q) begin
                pending_q <= 1'b1;  // Sticky until cleared
            end else if (wr_ctrl && req_i.wdata[1]) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.req) rdata_q <= rdata_d;
    end

    assign resp_o.gnt    = req_i.req;  // Always ready
    assign resp_o.rvalid = rvalid_q;
    assign resp_o.rdata  = rdata_q;
    assign irq_o         = pending_q;

endmodule

/* source/cpu_subsystem.sv */
////////////////////////////////////////////////////////////
// CPU subsystem wrapping the core FSM, register file and
// ALU, with fixed-priority interrupt selection
////////////////////////////////////////////////////////////
module cpu_subsystem #(
    parameter logic [31:0] BOOT_ADDR = 32'h0000_0000,
    parameter logic [31:0] IRQ_VEC   = 32'h0000_0100
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    output mcu_pkg::obi_req_t               instr_req_o,
    input  mcu_pkg::obi_resp_t              instr_resp_i,
    output mcu_pkg::obi_req_t               data_req_o,
    input  mcu_pkg::obi_resp_t              data_resp_i,
    input  logic [mcu_pkg::NUM_IRQ-1:0]     irq_i,
    output logic                            irq_ack_o,
    output logic [mcu_pkg::IRQ_ID_W-1:0]    irq_id_o,
    output logic                            core_sleep_o
);

    mcu_pkg::obi_req_t             fetch_req;
    mcu_pkg::opcode_e              alu_op;
    logic [3:0]                    rf_raddr_a, rf_raddr_b, rf_waddr;
    logic [31:0]                   rf_rdata_a, rf_rdata_b, rf_wdata;
    logic                          rf_we;
    logic [31:0]                   alu_b, alu_result;
    logic                          alu_equal;
    logic                          irq_taken;
    logic [mcu_pkg::IRQ_ID_W-1:0]  irq_id;

    // Lowest numbered line wins
    always_comb begin
        irq_id = '0;
        for (int i = mcu_pkg::NUM_IRQ - 1; i >= 0; i--) begin
            if (irq_i[i]) begin
                irq_id = i[mcu_pkg::IRQ_ID_W-1:0];
            end
        end
    end

    assign irq_ack_o = irq_taken;
    assign irq_id_o  = irq_taken ? irq_id : '0;

    // Fetches are always full-word reads
    always_comb begin
        instr_req_o       = fetch_req;
        instr_req_o.we    = 1'b0;
        instr_req_o.be    = 4'b1111;
        instr_req_o.wdata = '0;
    end

    core_ctrl_fsm #(
        .BOOT_ADDR(BOOT_ADDR),
        .IRQ_VEC  (IRQ_VEC)
    ) i_core_ctrl_fsm (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_req_o  (fetch_req),
        .instr_resp_i (instr_resp_i),
        .data_req_o   (data_req_o),
        .data_resp_i  (data_resp_i),
        .irq_pending_i(|irq_i),
        .irq_taken_o  (irq_taken),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata),
        .alu_op_o     (alu_op),
        .alu_b_o      (alu_b),
        .alu_result_i (alu_result),
        .alu_equal_i  (alu_equal),
        .sleep_o      (core_sleep_o)
    );

    core_regfile i_core_regfile (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .raddr_a_i(rf_raddr_a),
        .raddr_b_i(rf_raddr_b),
        .rdata_a_o(rf_rdata_a),
        .rdata_b_o(rf_rdata_b),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    core_alu i_core_alu (
        .op_i    (alu_op),
        .a_i     (rf_rdata_a),
        .b_i     (alu_b),
        .result_o(alu_result),
        .equal_o (alu_equal)
    );

endmodule

/* source/core_ctrl_fsm.sv */
////////////////////////////////////////////////////////////
// Core control FSM holding pc, instruction and interrupt
// state, sequencing the fetch and data handshakes
////////////////////////////////////////////////////////////
module core_ctrl_fsm #(
    parameter logic [31:0] BOOT_ADDR = 32'h0000_0000,
    parameter logic [31:0] IRQ_VEC   = 32'h0000_0100
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    output mcu_pkg::obi_req_t  instr_req_o,
    input  mcu_pkg::obi_resp_t instr_resp_i,
    output mcu_pkg::obi_req_t  data_req_o,
    input  mcu_pkg::obi_resp_t data_resp_i,
    input  logic               irq_pending_i,
    output logic               irq_taken_o,
    output logic [3:0]         rf_raddr_a_o,
    output logic [3:0]         rf_raddr_b_o,
    input  logic [31:0]        rf_rdata_a_i,
    input  logic [31:0]        rf_rdata_b_i,
    output logic               rf_we_o,
    output logic [3:0]         rf_waddr_o,
    output logic [31:0]        rf_wdata_o,
    output mcu_pkg::opcode_e   alu_op_o,
    output logic [31:0]        alu_b_o,
    input  logic [31:0]        alu_result_i,
    input  logic               alu_equal_i,
    output logic               sleep_o
);

    mcu_pkg::core_state_e state_q, state_d;
    mcu_pkg::opcode_e     opcode;
    logic [31:0]          pc_q, epc_q, instr_q;
    logic [31:0]          imm_sext, pc_plus4, pc_target;
    logic                 irq_en_q;
    logic                 to_fetch;  // Instruction boundary reached
    logic                 load_done;

    assign opcode   = mcu_pkg::opcode_e'(instr_q[31:28]);
    assign imm_sext = {{16{instr_q[15]}}, instr_q[15:0]};
    assign pc_plus4 = pc_q + 32'd4;

    assign rf_waddr_o   = instr_q[27:24];
    assign rf_raddr_a_o = instr_q[23:20];
    assign rf_raddr_b_o = instr_q[19:16];
    assign alu_op_o     = opcode;
    assign alu_b_o      = (opcode inside {mcu_pkg::OP_ADDI, mcu_pkg::OP_LW, mcu_pkg::OP_SW})
                          ? imm_sext : rf_rdata_b_i;

    always_comb begin
        state_d   = state_q;
        to_fetch  = 1'b0;
        pc_target = pc_plus4;
        case (state_q)
            mcu_pkg::ST_FETCH: begin
                if (instr_resp_i.gnt) state_d = mcu_pkg::ST_WAIT_INSTR;
            end
            mcu_pkg::ST_WAIT_INSTR: begin
                if (instr_resp_i.rvalid) state_d = mcu_pkg::ST_EXECUTE;
            end
            mcu_pkg::ST_EXECUTE: begin
                if (opcode inside {mcu_pkg::OP_LW, mcu_pkg::OP_SW}) begin
                    state_d = mcu_pkg::ST_MEM_REQ;
                end else if (opcode == mcu_pkg::OP_WFI) begin
                    state_d = mcu_pkg::ST_SLEEP;
                end else begin
                    to_fetch = 1'b1;
                    if (opcode == mcu_pkg::OP_BEQ && alu_equal_i) begin
                        pc_target = pc_plus4 + {imm_sext[29:0], 2'b00};
                    end else if (opcode == mcu_pkg::OP_IRET) begin
                        pc_target = epc_q;
                    end
                end
            end
            mcu_pkg::ST_MEM_REQ: begin
                if (data_resp_i.gnt) state_d = mcu_pkg::ST_WAIT_DATA;
            end
            mcu_pkg::ST_WAIT_DATA: to_fetch = data_resp_i.rvalid;
            mcu_pkg::ST_SLEEP:     to_fetch = irq_pending_i;  // Any line wakes
            default:               state_d  = mcu_pkg::ST_FETCH;
        endcase
        if (to_fetch) state_d = mcu_pkg::ST_FETCH;
    end

    // Interrupt entry happens on the way back into FETCH
    assign irq_taken_o = to_fetch & irq_en_q & irq_pending_i;

    always_comb begin
        instr_req_o      = '0;  // Constant fields come from the wrapper
        instr_req_o.req  = (state_q == mcu_pkg::ST_FETCH);
        instr_req_o.addr = pc_q;
    end

    always_comb begin
        data_req_o.req   = (state_q == mcu_pkg::ST_MEM_REQ);
        data_req_o.we    = (opcode == mcu_pkg::OP_SW);
        data_req_o.be    = 4'b1111;
        data_req_o.addr  = alu_result_i;  // rs1 + imm
        data_req_o.wdata = rf_rdata_b_i;
    end

    // Write-back select
    assign load_done = (state_q == mcu_pkg::ST_WAIT_DATA) & data_resp_i.rvalid
                       & (opcode == mcu_pkg::OP_LW);
    assign rf_we_o   = load_done | ((state_q == mcu_pkg::ST_EXECUTE) &
                       (opcode inside {mcu_pkg::OP_ADD, mcu_pkg::OP_SUB, mcu_pkg::OP_AND,
                                       mcu_pkg::OP_OR, mcu_pkg::OP_XOR, mcu_pkg::OP_ADDI,
                                       mcu_pkg::OP_LUI}));
    assign rf_wdata_o = (opcode == mcu_pkg::OP_LUI) ? {instr_q[15:0], 16'h0000} :
                        (opcode == mcu_pkg::OP_LW)  ? data_resp_i.rdata : alu_result_i;

    assign sleep_o = (state_q == mcu_pkg::ST_SLEEP);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= mcu_pkg::ST_FETCH;
            pc_q     <= BOOT_ADDR;
            epc_q    <= '0;
            irq_en_q <= 1'b1;
        end else begin
            state_q <= state_d;
            if (state_q == mcu_pkg::ST_EXECUTE && opcode == mcu_pkg::OP_IRET) begin
                irq_en_q <= 1'b1;
            end
            if (irq_taken_o) begin
                epc_q    <= pc_target;  // Resume point
                pc_q     <= IRQ_VEC;
                irq_en_q <= 1'b0;
            end else if (to_fetch) begin
                pc_q <= pc_target;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == mcu_pkg::ST_WAIT_INSTR && instr_resp_i.rvalid) begin
            instr_q <= instr_resp_i.rdata;
        end
    end

endmodule

/* source/core_alu.sv */
////////////////////////////////////////////////////////////
// Core ALU, add/sub/logic by opcode plus equality compare
////////////////////////////////////////////////////////////
module core_alu (
    input  mcu_pkg::opcode_e op_i,
    input  logic [31:0]      a_i,
    input  logic [31:0]      b_i,
    output logic [31:0]      result_o,
    output logic             equal_o
);

    always_comb begin
        case (op_i)
            // Address generation shares the adder
            mcu_pkg::OP_ADD,
            mcu_pkg::OP_ADDI,
            mcu_pkg::OP_LW,
            mcu_pkg::OP_SW:  result_o = a_i + b_i;
            mcu_pkg::OP_SUB: result_o = a_i - b_i;
            mcu_pkg::OP_AND: result_o = a_i & b_i;
            mcu_pkg::OP_OR:  result_o = a_i | b_i;
            mcu_pkg::OP_XOR: result_o = a_i ^ b_i;
            default:         result_o = '0;
        endcase
    end

    assign equal_o = (a_i == b_i);  // For BEQ

endmodule

/* source/core_regfile.sv */
////////////////////////////////////////////////////////////
// Sixteen by 32-bit register file, r0 reads zero
////////////////////////////////////////////////////////////
module core_regfile (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [3:0]  raddr_a_i,
    input  logic [3:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o,
    input  logic        we_i,
    input  logic [3:0]  waddr_i,
    input  logic [31:0] wdata_i
);

    logic [31:0] regs_q [16];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != 4'd0) begin  // r0 never written
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

/* source/mcu_pkg.sv */
////////////////////////////////////////////////////////////
// MCU package with OBI bus structs, core opcodes, states
// and timer register map
////////////////////////////////////////////////////////////
package mcu_pkg;

    parameter int unsigned NUM_IRQ  = 9;  // 0..7 external, 8 timer
    parameter int unsigned IRQ_ID_W = 4;

    // Timer register offsets inside its 4 KB window
    parameter logic [11:0] TIMER_COUNT_OFS = 12'h000;
    parameter logic [11:0] TIMER_CMP_OFS   = 12'h004;
    parameter logic [11:0] TIMER_CTRL_OFS  = 12'h008;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } obi_resp_t;

    // Instruction bits 31..28
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LUI  = 4'h6,
        OP_LW   = 4'h7,
        OP_SW   = 4'h8,
        OP_BEQ  = 4'h9,
        OP_WFI  = 4'hA,
        OP_IRET = 4'hB,
        OP_NOP  = 4'hF
    } opcode_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_WAIT_INSTR,
        ST_EXECUTE,
        ST_MEM_REQ,
        ST_WAIT_DATA,
        ST_SLEEP
    } core_state_e;

endpackage
